// File: common/vdp_pkg.sv
package vdp_pkg;

   typedef enum logic {
      MSX1,
      MSX2
   } msx_type_t;

   typedef enum logic {
      NTSC,
      PAL
   } video_mode_t;

   // Operation decoded from one CPU strobe.
   typedef enum logic [2:0] {
      OP_NONE,
      OP_VRAM_WR,
      OP_VRAM_RD,
      OP_CTRL_WR,
      OP_STATUS_RD
   } port_op_t;

   localparam int VRAM_ADDR_W = 17; // Two banks of 64 KiB.

   localparam logic [3:0] REG_MODE1  = 4'd1;
   localparam logic [3:0] REG_BORDER = 4'd7;
   localparam logic [3:0] REG_HIADDR = 4'd14;

   // TMS9918 colors as 8-bit red, green and blue.
   localparam logic [23:0] MSX1_PALETTE [16] = '{
      24'h000000, 24'h000000, 24'h21c842, 24'h5edc78,
      24'h5455ed, 24'h7d76fc, 24'hd4524d, 24'h42ebf5,
      24'hfc5554, 24'hff7978, 24'hd4c154, 24'he6ce80,
      24'h21b03b, 24'hc95bba, 24'hcccccc, 24'hffffff
   };

endpackage

// File: cpu_port/vdp_cpu_port.sv
`timescale 1ns/10ps

module vdp_cpu_port
   import vdp_pkg::*;
#(
   parameter int BANK_ADDR_W = 16
) (
   input  logic                   clock_bus,
   input  logic                   reset_i,
   input  msx_type_t              msx_type_i,
   input  logic                   cs_i,
   input  logic                   rd_i,
   input  logic                   wr_i,
   input  logic                   mode_i,
   input  logic [7:0]             data_i,
   input  logic                   vblank_start_i,
   input  logic [7:0]             ahead_i,
   output logic [7:0]             data_o,
   output logic                   interrupt_n_o,
   output logic [7:0]             border_o,
   output logic [BANK_ADDR_W-1:0] bank_addr_o,
   output logic [7:0]             bank_wdata_o,
   output logic [1:0]             bank_we_o,
   output logic                   rd_strobe_o,
   output logic                   rd_bank_o
);

   port_op_t               op;
   logic                   cpu_strobe;
   logic                   msx1;
   logic                   pair_second;
   logic [7:0]             ctrl_latch;
   logic [7:0]             reg_mode1;
   logic [2:0]             reg_hiaddr;
   logic [VRAM_ADDR_W-1:0] ptr;
   logic [VRAM_ADDR_W-1:0] ptr_setup;
   logic [VRAM_ADDR_W-1:0] access_ptr;
   logic                   vblank_flag;

   // MSX1 wraps inside 16 KiB so the pointer never leaves bank 0.
   function automatic logic [VRAM_ADDR_W-1:0] ptr_step(input logic [VRAM_ADDR_W-1:0] p,
                                                        input logic is_msx1);
      return is_msx1 ? {3'b000, p[13:0] + 14'd1} : p + 1'b1;
   endfunction

   assign msx1       = (msx_type_i == MSX1);
   assign cpu_strobe = cs_i & (rd_i | wr_i);
   assign ptr_setup  = {(msx1 ? 3'b000 : reg_hiaddr), data_i[5:0], ctrl_latch};
   assign access_ptr = (op == OP_CTRL_WR) ? ptr_setup : ptr;

   always_comb begin
      op = OP_NONE;
      if (cs_i && wr_i)
         op = mode_i ? OP_CTRL_WR : OP_VRAM_WR;
      else if (cs_i && rd_i)
         op = mode_i ? OP_STATUS_RD : OP_VRAM_RD;
   end

   assign data_o        = mode_i ? {vblank_flag, 7'b0} : ahead_i;
   assign interrupt_n_o = ~(vblank_flag & reg_mode1[5]);

   always_ff @(posedge clock_bus) begin
      if (reset_i) begin
         pair_second <= 1'b0;
         reg_mode1   <= '0;
         border_o    <= '0;
         reg_hiaddr  <= '0;
         ptr         <= '0;
         vblank_flag <= 1'b0;
         bank_we_o   <= 2'b00;
         rd_strobe_o <= 1'b0;
      end else begin
         bank_we_o   <= 2'b00;
         rd_strobe_o <= 1'b0;
         case (op)
            OP_VRAM_WR: begin
               bank_we_o   <= ptr[VRAM_ADDR_W-1] ? 2'b10 : 2'b01;
               ptr         <= ptr_step(ptr, msx1);
               pair_second <= 1'b0;
            end
            OP_VRAM_RD: begin
               rd_strobe_o <= 1'b1; // Prefetch for the next read.
               ptr         <= ptr_step(ptr, msx1);
               pair_second <= 1'b0;
            end
            OP_CTRL_WR: begin
               pair_second <= ~pair_second;
               if (pair_second && data_i[7]) begin
                  case (data_i[3:0])
                     REG_MODE1:  reg_mode1  <= ctrl_latch;
                     REG_BORDER: border_o   <= ctrl_latch;
                     REG_HIADDR: reg_hiaddr <= ctrl_latch[2:0];
                     default: ;
                  endcase
               end else if (pair_second && data_i[6]) begin
                  ptr <= ptr_setup; // Write setup.
               end else if (pair_second) begin
                  ptr         <= ptr_step(ptr_setup, msx1);
                  rd_strobe_o <= 1'b1;
               end
            end
            OP_STATUS_RD: begin
               vblank_flag <= 1'b0;
               pair_second <= 1'b0;
            end
            default: ;
         endcase
         if (vblank_start_i)
            vblank_flag <= 1'b1; // A new frame wins over a clearing read.
      end
   end

   always_ff @(posedge clock_bus) begin
      if (op == OP_CTRL_WR && !pair_second)
         ctrl_latch <= data_i;
      if (cpu_strobe) begin
         bank_addr_o  <= access_ptr[BANK_ADDR_W-1:0];
         rd_bank_o    <= access_ptr[VRAM_ADDR_W-1];
         bank_wdata_o <= data_i;
      end
   end

   // The read-ahead path needs a few cycles between accesses.
   a_strobe_spacing: assert property (@(posedge clock_bus) disable iff (reset_i)
      cpu_strobe |=> !cpu_strobe [*3])
      else $error("CPU strobes closer than four cycles apart");

endmodule

// File: vram/vram_bank.sv
`timescale 1ns/10ps

module vram_bank #(
   parameter int BANK_ADDR_W = 16
) (
   input  logic                   clock_bus,
   input  logic [BANK_ADDR_W-1:0] addr_i,
   input  logic [7:0]             wdata_i,
   input  logic                   we_i,
   output logic [7:0]             q_o
);

   logic [7:0] mem [2**BANK_ADDR_W];

   // Read data is registered every cycle, so q_o follows addr_i by one cycle.
   always_ff @(posedge clock_bus) begin
      if (we_i)
         mem[addr_i] <= wdata_i;
      q_o <= mem[addr_i];
   end

   // The address comes from the CPU port pointer a cycle earlier.
   a_write_addr_known: assert property (@(posedge clock_bus)
      we_i |-> !$isunknown(addr_i))
      else $error("VRAM write with unknown address bits");

endmodule

// File: vram/vram_read_merge.sv
`timescale 1ns/10ps

module vram_read_merge (
   input  logic            clock_bus,
   input  logic            reset_i,
   input  logic            rd_strobe_i,
   input  logic            rd_bank_i,
   input  logic [1:0][7:0] q_i,
   output logic [7:0]      ahead_o
);

   logic strobe_q;
   logic bank_q;

   always_ff @(posedge clock_bus) begin
      if (reset_i)
         strobe_q <= 1'b0;
      else
         strobe_q <= rd_strobe_i; // Bank data is ready one cycle later.
   end

   always_ff @(posedge clock_bus) begin
      bank_q <= rd_bank_i;
      if (strobe_q)
         ahead_o <= q_i[bank_q]; // Held until the next prefetch.
   end

endmodule

// File: video/video_timing.sv
`timescale 1ns/10ps

module video_timing
   import vdp_pkg::*;
#(
   parameter int H_TOTAL      = 342,
   parameter int H_ACTIVE     = 256,
   parameter int V_ACTIVE     = 192,
   parameter int V_TOTAL_NTSC = 262,
   parameter int V_TOTAL_PAL  = 313
) (
   input  logic        clock_bus,
   input  logic        reset_i,
   input  msx_type_t   msx_type_i,
   input  video_mode_t video_mode_i,
   output logic        ce_pix_o,
   output logic        hsync_o,
   output logic        vsync_o,
   output logic        de_o,
   output logic        hblank_o,
   output logic        vblank_o,
   output logic        vblank_start_o
);

   localparam int V_MAX    = (V_TOTAL_PAL > V_TOTAL_NTSC) ? V_TOTAL_PAL : V_TOTAL_NTSC;
   localparam int H_W      = $clog2(H_TOTAL);
   localparam int V_W      = $clog2(V_MAX);
   localparam int HS_START = H_ACTIVE + (H_TOTAL - H_ACTIVE) / 4;
   localparam int HS_END   = HS_START + (H_TOTAL - H_ACTIVE) / 4;
   localparam int VS_START = V_ACTIVE + 1; // Two sync lines after one blank line.
   localparam int VS_END   = VS_START + 2;

   logic           div_q;
   logic [H_W-1:0] h_cnt;
   logic [V_W-1:0] v_cnt;
   logic [V_W-1:0] v_last;

   assign ce_pix_o = (msx_type_i == MSX2) | div_q;
   assign v_last   = (video_mode_i == PAL) ? V_W'(V_TOTAL_PAL - 1) : V_W'(V_TOTAL_NTSC - 1);

   always_ff @(posedge clock_bus) begin
      if (reset_i) begin
         div_q <= 1'b0;
         h_cnt <= '0;
         v_cnt <= '0;
      end else begin
         div_q <= ~div_q;
         if (ce_pix_o) begin
            if (h_cnt == H_W'(H_TOTAL - 1)) begin
               h_cnt <= '0;
               v_cnt <= (v_cnt == v_last) ? '0 : v_cnt + 1'b1;
            end else begin
               h_cnt <= h_cnt + 1'b1;
            end
         end
      end
   end

   // Outputs are registered and lag the counters by one cycle.
   always_ff @(posedge clock_bus) begin
      if (reset_i) begin
         hsync_o        <= 1'b0;
         vsync_o        <= 1'b0;
         de_o           <= 1'b0;
         hblank_o       <= 1'b0;
         vblank_o       <= 1'b0;
         vblank_start_o <= 1'b0;
      end else begin
         hsync_o  <= (h_cnt >= H_W'(HS_START)) && (h_cnt < H_W'(HS_END));
         vsync_o  <= (v_cnt >= V_W'(VS_START)) && (v_cnt < V_W'(VS_END));
         de_o     <= (h_cnt < H_W'(H_ACTIVE)) && (v_cnt < V_W'(V_ACTIVE));
         hblank_o <= (h_cnt >= H_W'(H_ACTIVE));
         vblank_o <= (v_cnt >= V_W'(V_ACTIVE));
         vblank_start_o <= ce_pix_o && (h_cnt == '0) && (v_cnt == V_W'(V_ACTIVE));
      end
   end

endmodule

// File: video/color_out.sv
`timescale 1ns/10ps

module color_out
   import vdp_pkg::*;
(
   input  logic       clock_bus,
   input  logic       reset_i,
   input  msx_type_t  msx_type_i,
   input  logic [7:0] border_i,
   input  logic       hblank_i,
   input  logic       vblank_i,
   output logic [7:0] r_o,
   output logic [7:0] g_o,
   output logic [7:0] b_o
);

   logic [23:0] msx1_rgb;
   logic [5:0]  r6;
   logic [5:0]  g6;
   logic [5:0]  b6;

   assign msx1_rgb = MSX1_PALETTE[border_i[3:0]];

   // MSX2 border byte is GGGRRRBB.
   assign g6 = {border_i[7:5], border_i[7:5]};
   assign r6 = {border_i[4:2], border_i[4:2]};
   assign b6 = {3{border_i[1:0]}};

   always_ff @(posedge clock_bus) begin
      if (reset_i || hblank_i || vblank_i) begin
         {r_o, g_o, b_o} <= '0;
      end else if (msx_type_i == MSX1) begin
         {r_o, g_o, b_o} <= msx1_rgb;
      end else begin
         r_o <= {r6, r6[5:4]};
         g_o <= {g6, g6[5:4]};
         b_o <= {b6, b6[5:4]};
      end
   end

endmodule

// File: src/vdp_subsystem.sv
`timescale 1ns/10ps

module vdp_subsystem
   import vdp_pkg::*;
#(
   parameter int BANK_ADDR_W  = 16,
   parameter int H_TOTAL      = 342,
   parameter int H_ACTIVE     = 256,
   parameter int V_ACTIVE     = 192,
   parameter int V_TOTAL_NTSC = 262,
   parameter int V_TOTAL_PAL  = 313
) (
   input  logic        clock_bus,
   input  logic        reset_i,
   input  msx_type_t   msx_type_i,
   input  video_mode_t video_mode_i,
   input  logic        cs_i,
   input  logic        rd_i,
   input  logic        wr_i,
   input  logic        mode_i,
   input  logic [7:0]  data_i,
   output logic [7:0]  data_o,
   output logic        interrupt_n_o,
   output logic [7:0]  r_o,
   output logic [7:0]  g_o,
   output logic [7:0]  b_o,
   output logic        hsync_o,
   output logic        vsync_o,
   output logic        de_o,
   output logic        hblank_o,
   output logic        vblank_o,
   output logic        ce_pix_o
);

   logic [7:0]             border;
   logic [BANK_ADDR_W-1:0] bank_addr;
   logic [7:0]             bank_wdata;
   logic [1:0]             bank_we;
   logic                   rd_strobe;
   logic                   rd_bank;
   logic [1:0][7:0]        bank_q;
   logic [7:0]             ahead;
   logic                   vblank_start;

   vdp_cpu_port #(.BANK_ADDR_W(BANK_ADDR_W)) u_cpu_port (
      .clock_bus      (clock_bus),
      .reset_i        (reset_i),
      .msx_type_i     (msx_type_i),
      .cs_i           (cs_i),
      .rd_i           (rd_i),
      .wr_i           (wr_i),
      .mode_i         (mode_i),
      .data_i         (data_i),
      .vblank_start_i (vblank_start),
      .ahead_i        (ahead),
      .data_o         (data_o),
      .interrupt_n_o  (interrupt_n_o),
      .border_o       (border),
      .bank_addr_o    (bank_addr),
      .bank_wdata_o   (bank_wdata),
      .bank_we_o      (bank_we),
      .rd_strobe_o    (rd_strobe),
      .rd_bank_o      (rd_bank)
   );

   // Bank 0 is the low 64 KiB and bank 1 the high 64 KiB.
   for (genvar i = 0; i < 2; i++) begin : g_bank
      vram_bank #(.BANK_ADDR_W(BANK_ADDR_W)) u_bank (
         .clock_bus (clock_bus),
         .addr_i    (bank_addr),
         .wdata_i   (bank_wdata),
         .we_i      (bank_we[i]),
         .q_o       (bank_q[i])
      );
   end

   vram_read_merge u_read_merge (
      .clock_bus   (clock_bus),
      .reset_i     (reset_i),
      .rd_strobe_i (rd_strobe),
      .rd_bank_i   (rd_bank),
      .q_i         (bank_q),
      .ahead_o     (ahead)
   );

   video_timing #(
      .H_TOTAL      (H_TOTAL),
      .H_ACTIVE     (H_ACTIVE),
      .V_ACTIVE     (V_ACTIVE),
      .V_TOTAL_NTSC (V_TOTAL_NTSC),
      .V_TOTAL_PAL  (V_TOTAL_PAL)
   ) u_timing (
      .clock_bus      (clock_bus),
      .reset_i        (reset_i),
      .msx_type_i     (msx_type_i),
      .video_mode_i   (video_mode_i),
      .ce_pix_o       (ce_pix_o),
      .hsync_o        (hsync_o),
      .vsync_o        (vsync_o),
      .de_o           (de_o),
      .hblank_o       (hblank_o),
      .vblank_o       (vblank_o),
      .vblank_start_o (vblank_start)
   );

   color_out u_color_out (
      .clock_bus  (clock_bus),
      .reset_i    (reset_i),
      .msx_type_i (msx_type_i),
      .border_i   (border),
      .hblank_i   (hblank_o),
      .vblank_i   (vblank_o),
      .r_o        (r_o),
      .g_o        (g_o),
      .b_o        (b_o)
   );

endmodule

// File: dv/vdp_model.svh
// Expected state of the VRAM, the registers and the CPU port.
logic [7:0]  exp_mem [int]; // Kept across resets like the real RAM.
logic [7:0]  exp_regs [16];
logic [16:0] exp_ptr;
logic [7:0]  exp_latch;
logic [7:0]  exp_ahead;
logic        exp_second;
logic        exp_flag;
logic        exp_msx2;

function automatic logic [16:0] next_pointer(input logic [16:0] p);
   if (exp_msx2)
      return p + 17'd1;
   return {3'b000, p[13:0] + 14'd1}; // MSX1 stays inside 16 KiB.
endfunction

function automatic logic [7:0] peek_memory(input logic [16:0] a);
   return exp_mem.exists(a) ? exp_mem[a] : 8'h00;
endfunction

function automatic void clear_model(input logic msx2);
   exp_msx2   = msx2;
   exp_ptr    = '0;
   exp_second = 1'b0;
   exp_flag   = 1'b0;
   foreach (exp_regs[i])
      exp_regs[i] = 8'h00;
endfunction

// Returns the byte that a read should give.
function automatic logic [7:0] predict_access(input port_op_t op, input logic [7:0] d);
   logic [7:0] res;
   res = 8'h00;
   case (op)
      OP_VRAM_WR: begin
         exp_mem[exp_ptr] = d;
         exp_ptr          = next_pointer(exp_ptr);
         exp_second       = 1'b0;
      end
      OP_VRAM_RD: begin
         res        = exp_ahead;
         exp_ahead  = peek_memory(exp_ptr);
         exp_ptr    = next_pointer(exp_ptr);
         exp_second = 1'b0;
      end
      OP_CTRL_WR: begin
         if (!exp_second) begin
            exp_latch = d;
         end else if (d[7]) begin
            exp_regs[d[3:0]] = exp_latch;
         end else begin
            exp_ptr = {(exp_msx2 ? exp_regs[REG_HIADDR][2:0] : 3'b000), d[5:0], exp_latch};
            if (!d[6]) begin
               exp_ahead = peek_memory(exp_ptr);
               exp_ptr   = next_pointer(exp_ptr);
            end
         end
         exp_second = !exp_second;
      end
      OP_STATUS_RD: begin
         res        = {exp_flag, 7'b0};
         exp_flag   = 1'b0;
         exp_second = 1'b0;
      end
      default: ;
   endcase
   return res;
endfunction

function automatic logic [23:0] border_rgb(input logic [7:0] c, input logic msx2);
   logic [5:0] r6;
   logic [5:0] g6;
   logic [5:0] b6;
   if (!msx2)
      return MSX1_PALETTE[c[3:0]];
   g6 = {2{c[7:5]}};
   r6 = {2{c[4:2]}};
   b6 = {3{c[1:0]}};
   return {r6, r6[5:4], g6, g6[5:4], b6, b6[5:4]};
endfunction

function automatic int frame_cycles(input logic msx2, input logic pal);
   return H_TOTAL * (pal ? V_TOTAL_PAL : V_TOTAL_NTSC) * (msx2 ? 1 : 2);
endfunction

// File: dv/tb_vdp_subsystem.sv
`timescale 1ns/10ps

module tb_vdp_subsystem
   import vdp_pkg::*;
();

   localparam int H_TOTAL      = 20;
   localparam int H_ACTIVE     = 12;
   localparam int V_ACTIVE     = 6;
   localparam int V_TOTAL_NTSC = 10;
   localparam int V_TOTAL_PAL  = 13;
   localparam int WAIT_LIMIT   = 2000;
   localparam int BLOCKS       = 6;
   localparam int BLOCK_LEN    = 4;

   logic        clock_bus;
   logic        reset_i;
   msx_type_t   msx_type;
   video_mode_t video_mode;
   logic        cs;
   logic        rd;
   logic        wr;
   logic        mode;
   logic [7:0]  data_in;
   logic [7:0]  data_out;
   logic        irq_n;
   logic [7:0]  red;
   logic [7:0]  green;
   logic [7:0]  blue;
   logic        hsync;
   logic        vsync;
   logic        de;
   logic        hblank;
   logic        vblank;
   logic        ce_pix;
   logic [31:0] rng_state;

   `include "vdp_model.svh"

   vdp_subsystem #(
      .H_TOTAL      (H_TOTAL),
      .H_ACTIVE     (H_ACTIVE),
      .V_ACTIVE     (V_ACTIVE),
      .V_TOTAL_NTSC (V_TOTAL_NTSC),
      .V_TOTAL_PAL  (V_TOTAL_PAL)
   ) dut0 (
      .clock_bus     (clock_bus),
      .reset_i       (reset_i),
      .msx_type_i    (msx_type),
      .video_mode_i  (video_mode),
      .cs_i          (cs),
      .rd_i          (rd),
      .wr_i          (wr),
      .mode_i        (mode),
      .data_i        (data_in),
      .data_o        (data_out),
      .interrupt_n_o (irq_n),
      .r_o           (red),
      .g_o           (green),
      .b_o           (blue),
      .hsync_o       (hsync),
      .vsync_o       (vsync),
      .de_o          (de),
      .hblank_o      (hblank),
      .vblank_o      (vblank),
      .ce_pix_o      (ce_pix)
   );

   always #2 clock_bus = ~clock_bus;

   function automatic logic [31:0] xorshift32();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   task automatic stop_failed();
      $display("TEST FAILED");
      $fatal(1, "Simulation stopped at the first failure.");
   endtask

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         $display("** Error %s: expected %h, actual %h", name, exp, act);
         stop_failed();
      end
   endtask

   // One strobe, then five idle cycles before the next one.
   task automatic cpu_access(input string name, input port_op_t op, input logic [7:0] d);
      logic [7:0] exp;
      exp = predict_access(op, d);
      @(negedge clock_bus);
      cs      = 1'b1;
      wr      = (op == OP_VRAM_WR) || (op == OP_CTRL_WR);
      rd      = (op == OP_VRAM_RD) || (op == OP_STATUS_RD);
      mode    = (op == OP_CTRL_WR) || (op == OP_STATUS_RD);
      data_in = d;
      #1;
      if (rd)
         check_value(name, exp, data_out); // Read data is combinational.
      @(negedge clock_bus);
      cs = 1'b0;
      rd = 1'b0;
      wr = 1'b0;
      repeat (4) @(negedge clock_bus);
   endtask

   task automatic reg_write(input logic [3:0] num, input logic [7:0] value);
      cpu_access("register value", OP_CTRL_WR, value);
      cpu_access("register select", OP_CTRL_WR, {4'h8, num});
   endtask

   task automatic set_pointer(input logic [16:0] a, input logic for_read);
      if (exp_msx2)
         reg_write(REG_HIADDR, {5'b0, a[16:14]});
      cpu_access("pointer low", OP_CTRL_WR, a[7:0]);
      cpu_access("pointer high", OP_CTRL_WR, {1'b0, !for_read, a[13:8]});
   endtask

   task automatic write_block(input logic [16:0] a);
      logic [31:0] rnd;
      set_pointer(a, 1'b0);
      repeat (BLOCK_LEN) begin
         rnd = xorshift32();
         cpu_access("vram write", OP_VRAM_WR, rnd[7:0]);
      end
   endtask

   task automatic read_block(input string name, input logic [16:0] a);
      set_pointer(a, 1'b1);
      repeat (BLOCK_LEN)
         cpu_access(name, OP_VRAM_RD, 8'h00);
   endtask

   // Machine type and video mode change only under reset.
   task automatic apply_reset(input msx_type_t t, input video_mode_t m);
      @(negedge clock_bus);
      reset_i    = 1'b1;
      msx_type   = t;
      video_mode = m;
      repeat (16) @(negedge clock_bus);
      reset_i = 1'b0;
      clear_model(t == MSX2);
   endtask

   task automatic check_border(input string name);
      logic [31:0] rnd;
      logic        blank_q;
      logic        seen_vis;
      logic        seen_blank;
      int          n;
      rnd = xorshift32();
      reg_write(REG_BORDER, rnd[7:0]);
      seen_vis   = 1'b0;
      seen_blank = 1'b0;
      n          = 0;
      blank_q    = hblank | vblank; // Colors follow the blanks one cycle later.
      while (!(seen_vis && seen_blank)) begin
         @(negedge clock_bus);
         if (blank_q) begin
            check_value({name, " blanked"}, 32'h0, {red, green, blue});
            seen_blank = 1'b1;
         end else begin
            check_value(name, border_rgb(exp_regs[REG_BORDER], exp_msx2), {red, green, blue});
            seen_vis = 1'b1;
         end
         blank_q = hblank | vblank;
         n++;
         if (n > WAIT_LIMIT) begin
            $display("Border check never saw both visible and blanked pixels.");
            stop_failed();
         end
      end
   endtask

   task automatic wait_irq_low();
      int n;
      n = 0;
      while (irq_n !== 1'b0) begin
         @(negedge clock_bus);
         n++;
         if (n > WAIT_LIMIT) begin
            $display("The interrupt was never asserted.");
            stop_failed();
         end
      end
      exp_flag = 1'b1;
   endtask

   task automatic check_interrupt();
      int n;
      reg_write(REG_MODE1, 8'h20);
      // The second pass starts right after a fresh vblank.
      repeat (2) begin
         wait_irq_low();
         cpu_access("status after vblank", OP_STATUS_RD, 8'h00);
      end
      check_value("interrupt released", 32'h1, irq_n);
      cpu_access("second status read", OP_STATUS_RD, 8'h00);
      reg_write(REG_MODE1, 8'h00);
      for (n = 0; n < frame_cycles(1'b1, 1'b0) + H_TOTAL; n++) begin
         @(negedge clock_bus);
         check_value("interrupt masked", 32'h1, irq_n);
      end
   endtask

   // Also counts how often each timing output is active within the period.
   task automatic vsync_period(output int cycles, output int pix, output int act,
                               output int hbl, output int vbl, output int lines);
      logic prev;
      logic prev_hs;
      logic rose;
      prev    = vsync;
      prev_hs = hsync;
      rose    = 1'b0;
      cycles  = 0;
      pix     = 0;
      act     = 0;
      hbl     = 0;
      vbl     = 0;
      lines   = 0;
      while (!rose) begin
         @(negedge clock_bus);
         cycles++;
         rose = vsync && !prev;
         prev = vsync;
         pix += ce_pix;
         act += de;
         hbl += hblank;
         vbl += vblank;
         lines += (hsync && !prev_hs);
         prev_hs = hsync;
         if (cycles > WAIT_LIMIT) begin
            $display("vsync did not rise within the expected time.");
            stop_failed();
         end
      end
   endtask

   initial begin
      int          cycles;
      int          pix;
      int          act;
      int          hbl;
      int          vbl;
      int          lines;
      int          div;
      int          v_total;
      int          b;
      int          t;
      int          m;
      logic [31:0] rnd;
      logic [16:0] addr [BLOCKS];
      clock_bus  = 1'b0;
      reset_i    = 1'b1;
      msx_type   = MSX2;
      video_mode = NTSC;
      cs         = 1'b0;
      rd         = 1'b0;
      wr         = 1'b0;
      mode       = 1'b0;
      data_in    = 8'h00;
      rng_state  = 32'ha73b_8b63;

      apply_reset(MSX2, NTSC);
      for (b = 0; b < BLOCKS; b++) begin
         rnd     = xorshift32();
         addr[b] = {b[0], rnd[15:0]}; // Alternate between the banks.
         write_block(addr[b]);
      end
      for (b = 0; b < BLOCKS; b++)
         read_block("msx2 readback", addr[b]);
      repeat (3) check_border("msx2 border");
      check_interrupt();

      apply_reset(MSX1, NTSC);
      rnd = xorshift32();
      reg_write(REG_HIADDR, {5'b0, rnd[2:0] | 3'b001});
      for (b = 0; b < BLOCKS; b++) begin
         rnd     = xorshift32();
         addr[b] = {rnd[16:14], 1'b0, rnd[12:0]};
         write_block(addr[b]);
      end
      for (b = 0; b < BLOCKS; b++)
         read_block("msx1 readback", addr[b]);
      repeat (3) check_border("msx1 border");

      // MSX1 writes must sit in bank 0 below 16 KiB.
      apply_reset(MSX2, PAL);
      for (b = 0; b < BLOCKS; b++)
         read_block("msx1 data in bank 0", {3'b000, addr[b][13:0]});

      for (t = 0; t < 2; t++) begin
         for (m = 0; m < 2; m++) begin
            apply_reset(msx_type_t'(t), video_mode_t'(m));
            vsync_period(cycles, pix, act, hbl, vbl, lines);
            vsync_period(cycles, pix, act, hbl, vbl, lines);
            div     = (t == 1) ? 1 : 2;
            v_total = (m == 1) ? V_TOTAL_PAL : V_TOTAL_NTSC;
            check_value("frame period", frame_cycles(t == 1, m == 1), cycles);
            check_value("pixel enables", H_TOTAL * v_total, pix);
            check_value("active cycles", H_ACTIVE * V_ACTIVE * div, act);
            check_value("hblank cycles", (H_TOTAL - H_ACTIVE) * v_total * div, hbl);
            check_value("vblank cycles", H_TOTAL * (v_total - V_ACTIVE) * div, vbl);
            check_value("hsync pulses", v_total, lines);
         end
      end

      $display("TEST OK");
      $finish;
   end

endmodule

// File: all.f
+incdir+dv
common/vdp_pkg.sv
cpu_port/vdp_cpu_port.sv
vram/vram_bank.sv
vram/vram_read_merge.sv
video/video_timing.sv
video/color_out.sv
src/vdp_subsystem.sv
dv/tb_vdp_subsystem.sv
